// File: if_fetch.f
+incdir+sim
source/if_cfg_pkg.sv
source/if_ctrl_pkg.sv
source/if_pc_select.sv
source/if_fetch_fsm.sv
source/if_addr_counter.sv
source/if_id_reg.sv
source/if_stage_top.sv
sim/if_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the fetch stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f if_fetch.f --top-module if_stage_tb -o if_stage_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/if_stage_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1

// File: sim/if_stage_tb_checks.svh
// expected-value rules and typed compares for the including testbench module
// uses test_name, mem_pattern, err_lo, err_hi and the package imports of that module

`ifndef if_stage_tb_checks_svh
`define if_stage_tb_checks_svh

// every address of the instruction memory is readable
function automatic instr_t mem_word(input addr_t addr);
  return addr ^ mem_pattern;
endfunction

// marked window returns a bus error
function automatic logic in_err_window(input addr_t addr);
  return (addr >= err_lo) && (addr < err_hi);
endfunction

function automatic addr_t exc_vector(input exc_pc_sel_e esel, input addr_t mtvec,
                                     input exc_cause_t cause);
  irq_vec_t vec;
  vec = cause.irq_int ? nmi_irq_vec : cause.lower_cause;
  case (esel)
    // word table above the 256-byte base with bit 7 kept zero
    exc_pc_irq:     return (mtvec & 32'hFFFF_FF00) | (addr_t'(vec) << 2);
    exc_pc_dbd:     return dm_halt_addr;
    exc_pc_dbg_exc: return dm_exception_addr;
    default:        return mtvec & 32'hFFFF_FFFC;
  endcase
endfunction

function automatic addr_t exp_next_pc(input pc_sel_e sel, input exc_pc_sel_e esel,
                                      input exc_cause_t cause, input csr_pcs_t csrs,
                                      input addr_t boot, input addr_t jump);
  case (sel)
    pc_jump: return jump;
    pc_exc:  return exc_vector(esel, csrs.mtvec, cause);
    pc_eret: return csrs.mepc;
    pc_dret: return csrs.depc;
    default: return boot;
  endcase
endfunction

task automatic fail_run(input string msg);
  $display("%s", msg);
  $display("TEST FAILED");
  $fatal(1, "stopped at first error");
endtask

task automatic check_addr(input string what, input addr_t exp, input addr_t act);
  if (exp !== act) begin
    $display("ERR %s: %s expected %h actual %h", test_name, what, exp, act);
    fail_run("address mismatch");
  end
endtask

task automatic check_instr(input string what, input instr_t exp, input instr_t act);
  if (exp !== act) begin
    $display("ERR %s: %s expected %h actual %h", test_name, what, exp, act);
    fail_run("instruction mismatch");
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (exp !== act) begin
    $display("ERR %s: %s expected %b actual %b", test_name, what, exp, act);
    fail_run("flag mismatch");
  end
endtask

`endif

// File: sim/if_stage_tb.sv
// fetch stage testbench with a memory model on the instruction bus and a decode model
// inputs change 5 ns after the rising edge and outputs are sampled 2 ns after it

`timescale 1ns/1ns

module if_stage_tb;

  import if_cfg_pkg::*;
  import if_ctrl_pkg::*;

  localparam logic [31:0] seed       = 32'hc91f6077;
  localparam int          wait_limit = 1000;
  localparam addr_t       mem_pattern = 32'h5A3C_96E1;
  // bus error window lies inside the sequential run after boot
  localparam addr_t       err_lo     = 32'h0000_2040;
  localparam addr_t       err_hi     = 32'h0000_2060;

  logic       clk_i;
  logic       rst_ni;
  addr_t      boot_addr_i;
  logic       req_i;
  redirect_t  redirect_i;
  exc_cause_t exc_cause_i;
  csr_pcs_t   csr_pcs_i;
  addr_t      branch_target_i;
  logic       instr_req_o;
  addr_t      instr_addr_o;
  logic       instr_gnt_i;
  logic       instr_rvalid_i;
  instr_t     instr_rdata_i;
  logic       instr_bus_err_i;
  logic       instr_valid_clear_i;
  if_id_t     if_id_o;
  logic       instr_valid_id_o;
  logic       instr_new_id_o;
  addr_t      pc_set_target_o;
  logic       csr_mtvec_init_o;
  logic       if_busy_o;

  string      test_name;
  addr_t      exp_pc;
  int         delivered;
  logic       hold_clear;

  `include "if_stage_tb_checks.svh"

  if_stage_top dut_i (.*);

  always #50 clk_i = ~clk_i;

  task automatic step();
    @(posedge clk_i);
    #5;
  endtask

  task automatic wait_delivered(input int target);
    int cycles;
    cycles = 0;
    while (delivered < target) begin
      step();
      cycles++;
      if (cycles > wait_limit) fail_run("timeout waiting for delivered instructions");
    end
  endtask

  // want_req picks the request phase and otherwise waits for a response still in flight
  task automatic wait_bus(input logic want_req);
    int cycles;
    cycles = 0;
    while (want_req ? !instr_req_o : !(if_busy_o && !instr_req_o)) begin
      step();
      cycles++;
      if (cycles > wait_limit) fail_run("timeout waiting for bus phase");
    end
  endtask

  task automatic wait_held();
    int cycles;
    cycles = 0;
    while (!instr_valid_id_o) begin
      step();
      cycles++;
      if (cycles > wait_limit) fail_run("timeout waiting for a held instruction");
    end
  endtask

  // one-cycle pc_set strobe with the target checked while the strobe is up
  task automatic redirect_to(input pc_sel_e sel, input exc_pc_sel_e esel);
    addr_t exp;
    exp = exp_next_pc(sel, esel, exc_cause_i, csr_pcs_i, boot_addr_i, branch_target_i);
    redirect_i = '{pc_set: 1'b1, pc_sel: sel, exc_sel: esel};
    #1;
    check_addr("redirect target", exp, pc_set_target_o);
    check_bit("mtvec init", sel == pc_boot, csr_mtvec_init_o);
    exp_pc = exp;
    step();
    redirect_i.pc_set = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus and decode models
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    int    gnt_wait;
    int    rv_wait;
    logic  pend;
    logic  gnt_q;
    addr_t gnt_addr;
    addr_t pend_addr;
    gnt_wait  = -1;
    rv_wait   = 0;
    pend      = 1'b0;
    gnt_q     = 1'b0;
    gnt_addr  = '0;
    pend_addr = '0;
    forever begin
      step();
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      // grant driven last cycle with req up was accepted at this edge
      if (gnt_q) begin
        pend      = 1'b1;
        pend_addr = gnt_addr;
        rv_wait   = int'($urandom_range(2, 0));
        gnt_q     = 1'b0;
      end
      if (pend) begin
        if (rv_wait == 0) begin
          instr_rvalid_i  = 1'b1;
          instr_rdata_i   = mem_word(pend_addr);
          instr_bus_err_i = in_err_window(pend_addr);
          pend            = 1'b0;
        end else begin
          rv_wait--;
        end
      end else if (instr_req_o) begin
        if (gnt_wait < 0) gnt_wait = int'($urandom_range(3, 0));
        if (gnt_wait == 0) begin
          instr_gnt_i = 1'b1;
          gnt_q       = 1'b1;
          gnt_addr    = instr_addr_o;
          gnt_wait    = -1;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  // decode consumes the slot at random
  initial begin : decode_model
    forever begin
      step();
      instr_valid_clear_i = instr_valid_id_o && !hold_clear && ($urandom_range(2, 0) != 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard checks that every new entry is the next PC of the stream
  ////////////////////////////////////////////////////////////////////////////

  initial begin : scoreboard
    logic new_seen;
    new_seen = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      if (instr_new_id_o) begin
        if (new_seen) fail_run("new instruction flag held for two cycles");
        check_bit("valid with new", 1'b1, instr_valid_id_o);
        check_addr("delivered pc", exp_pc, if_id_o.pc);
        check_instr("delivered data", mem_word(exp_pc), if_id_o.instr);
        check_bit("fetch error", in_err_window(exp_pc), if_id_o.fetch_err);
        exp_pc = exp_pc + 32'd4;
        delivered++;
      end
      new_seen = instr_new_id_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    void'($urandom(seed));
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    boot_addr_i         = 32'h0000_2000;
    req_i               = 1'b0;
    redirect_i          = '{pc_set: 1'b0, pc_sel: pc_boot, exc_sel: exc_pc_exc};
    exc_cause_i         = '{irq_int: 1'b0, lower_cause: 5'd0};
    // mode bits of mtvec must not reach the PC and bit 7 must not reach an irq vector
    csr_pcs_i           = '{mepc: 32'h0000_4204, depc: 32'h0000_5308, mtvec: 32'h0000_6183};
    branch_target_i     = 32'h0000_3100;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    instr_valid_clear_i = 1'b0;
    hold_clear          = 1'b0;
    delivered           = 0;
    exp_pc              = '0;
    test_name           = "reset";
    repeat (2) @(posedge clk_i);
    #5;
    check_bit("req", 1'b0, instr_req_o);
    check_bit("valid", 1'b0, instr_valid_id_o);
    check_bit("new", 1'b0, instr_new_id_o);
    check_bit("busy", 1'b0, if_busy_o);
    rst_ni = 1'b1;
    step();

    test_name = "boot";
    req_i = 1'b1;
    redirect_to(pc_boot, exc_pc_exc);
    wait_delivered(1);
    // runs through the error window and past it
    test_name = "sequential";
    wait_delivered(28);

    test_name = "jump";
    redirect_to(pc_jump, exc_pc_exc);
    wait_delivered(delivered + 3);
    test_name = "eret";
    redirect_to(pc_eret, exc_pc_exc);
    wait_delivered(delivered + 3);
    test_name = "dret";
    redirect_to(pc_dret, exc_pc_exc);
    wait_delivered(delivered + 3);
    test_name = "exception";
    redirect_to(pc_exc, exc_pc_exc);
    wait_delivered(delivered + 3);
    test_name = "external irq";
    exc_cause_i = '{irq_int: 1'b0, lower_cause: 5'd5};
    redirect_to(pc_exc, exc_pc_irq);
    wait_delivered(delivered + 3);
    test_name = "internal irq";
    exc_cause_i = '{irq_int: 1'b1, lower_cause: 5'd3};
    redirect_to(pc_exc, exc_pc_irq);
    wait_delivered(delivered + 3);
    test_name = "debug halt";
    redirect_to(pc_exc, exc_pc_dbd);
    wait_delivered(delivered + 3);
    test_name = "debug exception";
    redirect_to(pc_exc, exc_pc_dbg_exc);
    wait_delivered(delivered + 3);

    test_name = "squash in flight";
    branch_target_i = 32'h0000_3800;
    wait_bus(1'b0);
    redirect_to(pc_jump, exc_pc_exc);
    wait_delivered(delivered + 3);
    test_name = "squash in request";
    wait_bus(1'b1);
    redirect_to(pc_eret, exc_pc_exc);
    wait_delivered(delivered + 3);

    test_name = "squash held";
    #1 hold_clear = 1'b1;
    step();
    wait_held();
    redirect_to(pc_dret, exc_pc_exc);
    check_bit("valid after squash", 1'b0, instr_valid_id_o);
    #1 hold_clear = 1'b0;
    step();
    wait_delivered(delivered + 3);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: source/if_addr_counter.sv
// fetch address counter, steps one word per accepted request
// a redirect wins over a grant in the same cycle

`timescale 1ns/1ns

module if_addr_counter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              pc_set_i,
  input  if_cfg_pkg::addr_t next_pc_i,
  input  logic              grant_i,
  output if_cfg_pkg::addr_t fetch_addr_o,
  output if_cfg_pkg::addr_t resp_addr_o
);

  import if_cfg_pkg::*;

  addr_t fetch_addr_q;
  addr_t resp_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
    end else if (pc_set_i) begin
      fetch_addr_q <= next_pc_i;
    end else if (grant_i) begin
      fetch_addr_q <= fetch_addr_q + word_bytes;
    end
  end

  // PC of the request in flight, tags its response
  always_ff @(posedge clk_i) begin
    if (grant_i) begin
      resp_addr_q <= fetch_addr_q;
    end
  end

  assign fetch_addr_o = fetch_addr_q;
  assign resp_addr_o  = resp_addr_q;

  // whatever the redirect source, the bus only ever sees word addresses
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    grant_i |-> (fetch_addr_q[1:0] == 2'b00))
    else $error("misaligned fetch address accepted");

endmodule

// File: source/if_cfg_pkg.sv
// fetch stage widths and fixed addresses for a 32-bit core, no compressed instructions
// debug entry points match the debug module's default base address

package if_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned addr_w    = 32;
  localparam int unsigned instr_w   = 32;
  localparam int unsigned irq_vec_w = 5;

  // byte address on the instruction bus
  typedef logic [addr_w-1:0]    addr_t;
  // raw instruction word as returned by memory
  typedef logic [instr_w-1:0]   instr_t;
  // index into the vectored interrupt table
  typedef logic [irq_vec_w-1:0] irq_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // fixed addresses and steps
  ////////////////////////////////////////////////////////////////////////////

  // debug module entry points
  localparam addr_t dm_halt_addr      = 32'h1A110800;
  localparam addr_t dm_exception_addr = 32'h1A110808;

  // every internal interrupt lands on the last table slot
  localparam irq_vec_t nmi_irq_vec = 5'd31;

  // one word per fetch
  localparam addr_t word_bytes = 32'd4;

endpackage

// File: source/if_ctrl_pkg.sv
// control encodings and bundled signals of the fetch stage
// struct field order is fixed, other blocks pack these values directly

package if_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // selectors and states
  ////////////////////////////////////////////////////////////////////////////

  // source of the new PC on a redirect
  typedef enum logic [2:0] {
    pc_boot = 3'd0,
    pc_jump = 3'd1,
    pc_exc  = 3'd2,
    pc_eret = 3'd3,
    pc_dret = 3'd4
  } pc_sel_e;

  // kind of trap entry when pc_exc is selected
  typedef enum logic [1:0] {
    exc_pc_exc     = 2'd0,
    exc_pc_irq     = 2'd1,
    exc_pc_dbd     = 2'd2,
    exc_pc_dbg_exc = 2'd3
  } exc_pc_sel_e;

  // bus side of fetch, one request in flight at most
  typedef enum logic [1:0] {
    idle        = 2'd0,
    req         = 2'd1,
    wait_rvalid = 2'd2,
    drop        = 2'd3
  } fetch_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 irq_int;     // internal source, forced onto the NMI slot
    if_cfg_pkg::irq_vec_t lower_cause;
  } exc_cause_t;

  typedef struct packed {
    logic        pc_set;  // single-cycle strobe
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_sel;
  } redirect_t;

  typedef struct packed {
    if_cfg_pkg::addr_t mepc;
    if_cfg_pkg::addr_t depc;
    if_cfg_pkg::addr_t mtvec;
  } csr_pcs_t;

  // contents of the IF-ID slot
  typedef struct packed {
    if_cfg_pkg::instr_t instr;
    if_cfg_pkg::addr_t  pc;
    logic               fetch_err;
  } if_id_t;

endpackage

// File: source/if_fetch_fsm.sv
// bus FSM for a request/grant/valid bus with one request outstanding
// a new request starts only while the IF-ID slot is free, which keeps the single response
// slot from ever overflowing

`timescale 1ns/1ns

module if_fetch_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic pc_set_i,
  input  logic slot_free_i,
  input  logic instr_gnt_i,
  input  logic instr_rvalid_i,
  output logic instr_req_o,
  output logic grant_o,
  output logic resp_keep_o,
  output logic busy_o
);

  import if_ctrl_pkg::*;

  fetch_state_e state_q, state_d;

  assign instr_req_o = (state_q == req);
  // acceptance cycle of the bus
  assign grant_o     = instr_req_o & instr_gnt_i;
  // a redirect in the same cycle kills the response
  assign resp_keep_o = (state_q == wait_rvalid) & instr_rvalid_i & ~pc_set_i;
  assign busy_o      = (state_q != idle);

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      idle: begin
        if (req_i && slot_free_i) begin
          state_d = req;
        end
      end
      req: begin
        if (instr_gnt_i) begin
          // granted address is already stale if a redirect arrives with the grant
          state_d = pc_set_i ? drop : wait_rvalid;
        end else if (!req_i) begin
          // nothing accepted yet, request may be withdrawn
          state_d = idle;
        end
      end
      wait_rvalid: begin
        if (instr_rvalid_i) begin
          // response ends the transfer, kept or squashed
          state_d = idle;
        end else if (pc_set_i) begin
          state_d = drop;
        end
      end
      drop: begin
        // swallow the orphaned response
        if (instr_rvalid_i) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // memory must never answer without an accepted request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> (state_q inside {wait_rvalid, drop}))
    else $error("rvalid without outstanding request");

endmodule

// File: source/if_id_reg.sv
// IF-ID slot, one instruction held until decode clears it
// a redirect squashes the held instruction in the same edge

`timescale 1ns/1ns

module if_id_reg (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                resp_keep_i,
  input  logic                pc_set_i,
  input  if_cfg_pkg::instr_t  instr_rdata_i,
  input  logic                instr_bus_err_i,
  input  if_cfg_pkg::addr_t   resp_addr_i,
  input  logic                instr_valid_clear_i,
  output logic                slot_free_o,
  output if_ctrl_pkg::if_id_t if_id_o,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o
);

  logic valid_q, valid_d;
  logic new_q;

  // decode may free the slot in the cycle it consumes it
  assign slot_free_o = ~valid_q | instr_valid_clear_i;

  // held until cleared or squashed
  assign valid_d = resp_keep_i | (valid_q & ~instr_valid_clear_i & ~pc_set_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // single-cycle marker of a fresh entry
      new_q   <= resp_keep_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_keep_i) begin
      if_id_o.instr     <= instr_rdata_i;
      if_id_o.pc        <= resp_addr_i;
      if_id_o.fetch_err <= instr_bus_err_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // the FSM only starts a fetch into a free slot, so a response never lands on a held entry
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_keep_i |-> (!valid_q || instr_valid_clear_i))
    else $error("response overwrites a held instruction");

endmodule

// File: source/if_pc_select.sv
// next-PC selection, purely combinational
// mtvec is taken as 256-byte aligned in vectored mode, its low byte is ignored there
// the jump target must already be word aligned, no compressed support

`timescale 1ns/1ns

module if_pc_select (
  input  if_ctrl_pkg::redirect_t  redirect_i,
  input  if_ctrl_pkg::exc_cause_t exc_cause_i,
  input  if_ctrl_pkg::csr_pcs_t   csr_pcs_i,
  input  if_cfg_pkg::addr_t       boot_addr_i,
  input  if_cfg_pkg::addr_t       branch_target_i,
  output if_cfg_pkg::addr_t       next_pc_o,
  output logic                    csr_mtvec_init_o
);

  import if_cfg_pkg::*;
  import if_ctrl_pkg::*;

  irq_vec_t irq_vec;
  addr_t    exc_pc;

  ////////////////////////////////////////////////////////////////////////////
  // trap vector
  ////////////////////////////////////////////////////////////////////////////

  // internal interrupts share the NMI slot
  assign irq_vec = exc_cause_i.irq_int ? nmi_irq_vec : exc_cause_i.lower_cause;

  always_comb begin : exc_pc_mux
    unique case (redirect_i.exc_sel)
      // direct mode, base only
      exc_pc_exc:     exc_pc = {csr_pcs_i.mtvec[31:2], 2'b00};
      // vectored, one word per cause
      exc_pc_irq:     exc_pc = {csr_pcs_i.mtvec[31:8], 1'b0, irq_vec, 2'b00};
      exc_pc_dbd:     exc_pc = dm_halt_addr;
      exc_pc_dbg_exc: exc_pc = dm_exception_addr;
      default:        exc_pc = {csr_pcs_i.mtvec[31:2], 2'b00};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next PC
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : next_pc_mux
    unique case (redirect_i.pc_sel)
      pc_boot: next_pc_o = boot_addr_i;
      pc_jump: next_pc_o = branch_target_i;
      pc_exc:  next_pc_o = exc_pc;
      // return from trap or debug
      pc_eret: next_pc_o = csr_pcs_i.mepc;
      pc_dret: next_pc_o = csr_pcs_i.depc;
      default: next_pc_o = boot_addr_i;
    endcase
  end

  // boot redirect also seeds mtvec in the CSR file
  assign csr_mtvec_init_o = redirect_i.pc_set & (redirect_i.pc_sel == pc_boot);

  // selector sanity, only sampled on a real redirect
  always_comb begin : redirect_checks
    if (redirect_i.pc_set && redirect_i.pc_sel == pc_boot) begin
      assert (boot_addr_i[7:0] == 8'h00)
        else $error("boot address not 256-byte aligned");
    end
    if (redirect_i.pc_set && redirect_i.pc_sel == pc_exc) begin
      assert (!$isunknown(redirect_i.exc_sel))
        else $error("exception select unknown on redirect");
    end
    if (redirect_i.pc_set && redirect_i.pc_sel == pc_jump) begin
      assert (branch_target_i[1:0] == 2'b00)
        else $error("jump target not word aligned");
    end
  end

endmodule

// File: source/if_stage_top.sv
// instruction fetch stage top, word fetch without cache or prediction
// pc_set_target_o and csr_mtvec_init_o are combinational from redirect_i
// outputs of if_id_o are only meaningful while instr_valid_id_o is high

`timescale 1ns/1ns

module if_stage_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  if_cfg_pkg::addr_t       boot_addr_i,
  input  logic                    req_i,
  input  if_ctrl_pkg::redirect_t  redirect_i,
  input  if_ctrl_pkg::exc_cause_t exc_cause_i,
  input  if_ctrl_pkg::csr_pcs_t   csr_pcs_i,
  input  if_cfg_pkg::addr_t       branch_target_i,
  // instruction bus
  output logic                    instr_req_o,
  output if_cfg_pkg::addr_t       instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  if_cfg_pkg::instr_t      instr_rdata_i,
  input  logic                    instr_bus_err_i,
  // decode side
  input  logic                    instr_valid_clear_i,
  output if_ctrl_pkg::if_id_t     if_id_o,
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output if_cfg_pkg::addr_t       pc_set_target_o,
  output logic                    csr_mtvec_init_o,
  output logic                    if_busy_o
);

  import if_cfg_pkg::*;

  logic  grant;
  logic  resp_keep;
  logic  slot_free;
  addr_t resp_addr;

  // selected target also feeds the counter load
  if_pc_select u_pc_select (
    .redirect_i       (redirect_i),
    .exc_cause_i      (exc_cause_i),
    .csr_pcs_i        (csr_pcs_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .next_pc_o        (pc_set_target_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_fetch_fsm u_fetch_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (redirect_i.pc_set),
    .slot_free_i    (slot_free),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .grant_o        (grant),
    .resp_keep_o    (resp_keep),
    .busy_o         (if_busy_o)
  );

  if_addr_counter u_addr_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pc_set_i     (redirect_i.pc_set),
    .next_pc_i    (pc_set_target_o),
    .grant_i      (grant),
    .fetch_addr_o (instr_addr_o),
    .resp_addr_o  (resp_addr)
  );

  if_id_reg u_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .resp_keep_i         (resp_keep),
    .pc_set_i            (redirect_i.pc_set),
    .instr_rdata_i       (instr_rdata_i),
    .instr_bus_err_i     (instr_bus_err_i),
    .resp_addr_i         (resp_addr),
    .instr_valid_clear_i (instr_valid_clear_i),
    .slot_free_o         (slot_free),
    .if_id_o             (if_id_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o)
  );

endmodule
